/* dual_issue_cfg.svh */
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// datapath widths.
`define INST_WIDTH          32
`define ADDR_WIDTH          16
`define NUM_REGISTERS_LOG2  5
`define OP_CODE_BITS        6

// instruction field positions.
`define OPCODE_MSB          31
`define OPCODE_LSB          26
`define REG_RS_MSB          25
`define REG_RS_LSB          21
`define REG_RT_MSB          20
`define REG_RT_LSB          16
`define REG_RD_MSB          15
`define REG_RD_LSB          11

// opcode map, the top two bits select the class.
// 00xxxx register alu, 01xxxx immediate alu, 10xxxx memory, 11xxxx jumps.
`define OP_CODE_NOP         6'b000000
`define OP_CODE_JR          6'b001000

// compares and tests feed the branch pipe.
`define OP_CODE_CMP         6'b001010
`define OP_CODE_TEST        6'b001011
`define OP_CODE_CMPI        6'b011010
`define OP_CODE_TESTI       6'b011011

// memory ops.
`define OP_CODE_LW          6'b100000  // rt <- mem[rs + imm].
`define OP_CODE_SW          6'b100001  // mem[rs + imm] <- rt.
`define OP_CODE_LA          6'b100010  // rt <- mem[imm].
`define OP_CODE_SA          6'b100011  // mem[imm] <- rt.

// jumps occupy the rest of 11xxxx and carry no register fields.





`endif

/* dual_issue_pkg.sv */
`include "dual_issue_cfg.svh"

package dual_issue_pkg;

  // which instruction fields name a register.
  typedef struct packed {
    logic rs;
    logic rt;
    logic rd;
  } reg_mask_t;

  // one bit per pipeline register, shared by stall, nop and flush.
  typedef struct packed {
    logic pc;
    logic if_id;
    logic id_ex;
  } pipe_mask_t;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_read  = 2'd1,
    mem_write = 2'd2
  } mem_op_t;

  // pipe an instruction may be steered to.
  typedef enum logic [1:0] {
    pipe_dont_care = 2'd0,
    pipe_memory    = 2'd1,
    pipe_branch    = 2'd2
  } pipe_class_t;

  // fetched slot.
  typedef struct packed {
    logic                   valid;
    logic [`INST_WIDTH-1:0] inst;
  } if_id_t;

  // issued slot, mem_op kept so EX can flag a pending load.
  typedef struct packed {
    logic                   valid;
    logic [`INST_WIDTH-1:0] inst;
    mem_op_t                mem_op;
  } id_ex_t;









endpackage

/* slot_decode_if.sv */
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

interface slot_decode_if;

  logic [`OP_CODE_BITS-1:0]       opcode;
  logic [`NUM_REGISTERS_LOG2-1:0] rs;
  logic [`NUM_REGISTERS_LOG2-1:0] rt;
  logic [`NUM_REGISTERS_LOG2-1:0] rd;
  dual_issue_pkg::reg_mask_t      src_mask;   // fields read.
  dual_issue_pkg::reg_mask_t      dst_mask;   // field written.
  dual_issue_pkg::pipe_class_t    pipe_class;

  // decoder drives one lane.
  modport decoder (
    output opcode, rs, rt, rd,
    output src_mask, dst_mask, pipe_class
  );

  // hazard unit looks at both lanes.
  modport hazard (
    input opcode, rs, rt, rd,
    input src_mask, dst_mask, pipe_class
  );

endinterface

/* inst_decode.sv */
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module inst_decode (
  input  logic [`INST_WIDTH-1:0]  inst,
  slot_decode_if.decoder          slot,
  output dual_issue_pkg::mem_op_t mem_op
);

  logic [`OP_CODE_BITS-1:0] opcode;

  assign opcode      = inst[`OPCODE_MSB:`OPCODE_LSB];
  assign slot.opcode = opcode;
  assign slot.rs     = inst[`REG_RS_MSB:`REG_RS_LSB];
  assign slot.rt     = inst[`REG_RT_MSB:`REG_RT_LSB];
  assign slot.rd     = inst[`REG_RD_MSB:`REG_RD_LSB];

  // nop and jr sit inside the register alu class, so they are matched first.
  always_comb begin
    slot.src_mask   = '0;
    slot.dst_mask   = '0;
    slot.pipe_class = dual_issue_pkg::pipe_dont_care;
    mem_op          = dual_issue_pkg::mem_none;
    case (opcode) inside
      `OP_CODE_NOP: ; // reads and writes nothing.
      `OP_CODE_JR: begin
        slot.src_mask.rs = 1'b1;
      end
      6'b00????: begin // add, sub, cmp, ...
        slot.src_mask.rs = 1'b1;
        slot.src_mask.rt = 1'b1;
        slot.dst_mask.rd = 1'b1;
        if (opcode == `OP_CODE_CMP || opcode == `OP_CODE_TEST) begin
          slot.pipe_class = dual_issue_pkg::pipe_branch;
        end
      end
      6'b01????: begin // addi, subi, cmpi, ...
        slot.src_mask.rs = 1'b1;
        slot.dst_mask.rt = 1'b1;
        if (opcode == `OP_CODE_CMPI || opcode == `OP_CODE_TESTI) begin
          slot.pipe_class = dual_issue_pkg::pipe_branch;
        end
      end
      6'b10????: begin
        slot.pipe_class = dual_issue_pkg::pipe_memory;
        case (opcode)
          `OP_CODE_LW: begin
            slot.src_mask.rs = 1'b1;
            slot.dst_mask.rt = 1'b1;
            mem_op           = dual_issue_pkg::mem_read;
          end
          `OP_CODE_SW: begin
            slot.src_mask.rs = 1'b1;
            slot.src_mask.rt = 1'b1;
            mem_op           = dual_issue_pkg::mem_write;
          end
          `OP_CODE_LA: begin // absolute address, no base register.
            slot.dst_mask.rt = 1'b1;
            mem_op           = dual_issue_pkg::mem_read;
          end
          `OP_CODE_SA: begin
            slot.src_mask.rt = 1'b1;
            mem_op           = dual_issue_pkg::mem_write;
          end
          default: ; // unused memory opcodes decode as nops.
        endcase
      end
      6'b11????: begin // jmp, jo, je, ...
        slot.pipe_class = dual_issue_pkg::pipe_branch;
      end
    endcase
  end

  // split detection picks rt or rd, so at most one destination field.
  always_comb begin
    assert final ($onehot0(slot.dst_mask))
      else $error("inst_decode: several destinations for opcode %b", opcode);
  end

endmodule

/* hazard_detection_unit.sv */
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module hazard_detection_unit (
  input  logic [`INST_WIDTH-1:0]     load_instruction,
  input  dual_issue_pkg::mem_op_t    mem_op,
  input  logic                       first,
  slot_decode_if.hazard              slot0,
  slot_decode_if.hazard              slot1,
  output dual_issue_pkg::pipe_mask_t stall0,
  output dual_issue_pkg::pipe_mask_t nop0,
  output dual_issue_pkg::pipe_mask_t stall1,
  output dual_issue_pkg::pipe_mask_t nop1,
  output dual_issue_pkg::pipe_mask_t flush0,
  output dual_issue_pkg::pipe_mask_t flush1
);

  logic [`NUM_REGISTERS_LOG2-1:0] load_rt;
  logic                           load_hit0;
  logic                           load_hit1;
  logic                           load_stall;
  logic                           split_hit;
  logic                           split_stall;
  dual_issue_pkg::reg_mask_t      young_src;
  logic [`NUM_REGISTERS_LOG2-1:0] young_rs;
  logic [`NUM_REGISTERS_LOG2-1:0] young_rt;
  dual_issue_pkg::reg_mask_t      old_dst;
  logic [`NUM_REGISTERS_LOG2-1:0] old_rt;
  logic [`NUM_REGISTERS_LOG2-1:0] old_rd;
  logic [`NUM_REGISTERS_LOG2-1:0] old_dst_reg;

  assign load_rt = load_instruction[`REG_RT_MSB:`REG_RT_LSB];

  // only fields the decoder marks as sources can depend on the load.
  assign load_hit0  = (slot0.src_mask.rs && slot0.rs == load_rt) ||
                      (slot0.src_mask.rt && slot0.rt == load_rt);
  assign load_hit1  = (slot1.src_mask.rs && slot1.rs == load_rt) ||
                      (slot1.src_mask.rt && slot1.rt == load_rt);
  assign load_stall = (mem_op == dual_issue_pkg::mem_read) && (load_hit0 || load_hit1);

  // first set means lane 1 is older and lane 0 reads behind it.
  always_comb begin
    if (first) begin
      young_src = slot0.src_mask;
      young_rs  = slot0.rs;
      young_rt  = slot0.rt;
      old_dst   = slot1.dst_mask;
      old_rt    = slot1.rt;
      old_rd    = slot1.rd;
    end else begin
      young_src = slot1.src_mask;
      young_rs  = slot1.rs;
      young_rt  = slot1.rt;
      old_dst   = slot0.dst_mask;
      old_rt    = slot0.rt;
      old_rd    = slot0.rd;
    end
  end

  assign old_dst_reg = old_dst.rd ? old_rd : old_rt;

  assign split_hit   = (old_dst.rt || old_dst.rd) &&
                       ((young_src.rs && young_rs == old_dst_reg) ||
                        (young_src.rt && young_rt == old_dst_reg));
  assign split_stall = !load_stall && split_hit; // load stall takes priority.

  // reserved for steering, never raised here.
  assign nop0 = '0;
  assign nop1 = '0;

  always_comb begin
    stall0 = '0;
    stall1 = '0;
    flush0 = '0;
    flush1 = '0;
    if (load_stall) begin
      // whole pair waits one cycle, bubble into EX.
      stall0.pc    = 1'b1;
      stall0.if_id = 1'b1;
      flush0.id_ex = 1'b1;
      stall1.pc    = 1'b1;
      stall1.if_id = 1'b1;
      flush1.id_ex = 1'b1;
    end else if (split_stall) begin
      if (first) begin
        stall0.pc    = 1'b1; // lane 0 waits in ID.
        stall0.if_id = 1'b1;
        flush0.id_ex = 1'b1;
        stall1.pc    = 1'b1; // lane 1 issues, its slot empties.
        flush1.if_id = 1'b1;
      end else begin
        stall1.pc    = 1'b1;
        stall1.if_id = 1'b1;
        flush1.id_ex = 1'b1;
        stall0.pc    = 1'b1;
        flush0.if_id = 1'b1;
      end
    end
  end

  // a stage register cannot hold and take a bubble in the same cycle.
  always_comb begin
    assert final (((stall0 & flush0) == '0) && ((stall1 & flush1) == '0))
      else $error("hazard_detection_unit: stall and flush overlap");
  end

endmodule

/* stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,  // keep current contents.
  input  logic     flush,  // load a bubble.
  input  payload_t d,
  output payload_t q
);

  // an all zero payload has its valid bit low.
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

  // hazard masks never put both on one register.
  assert property (@(posedge clk) disable iff (reset) !(stall && flush))
    else $error("stage_reg: stall and flush together");

endmodule

/* dual_issue_front.sv */
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module dual_issue_front (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`INST_WIDTH-1:0] inst0,  // word at pc.
  input  logic [`INST_WIDTH-1:0] inst1,  // word at pc + 1.
  input  logic                   first,
  output logic [`ADDR_WIDTH-1:0] pc,
  output logic                   ex0_valid,
  output logic [`INST_WIDTH-1:0] ex0_inst,
  output logic                   ex1_valid,
  output logic [`INST_WIDTH-1:0] ex1_inst
);

  dual_issue_pkg::if_id_t     if_id0_d;
  dual_issue_pkg::if_id_t     if_id0_q;
  dual_issue_pkg::if_id_t     if_id1_d;
  dual_issue_pkg::if_id_t     if_id1_q;
  dual_issue_pkg::id_ex_t     id_ex0_d;
  dual_issue_pkg::id_ex_t     id_ex0_q;
  dual_issue_pkg::id_ex_t     id_ex1_d;
  dual_issue_pkg::id_ex_t     id_ex1_q;
  dual_issue_pkg::mem_op_t    mem_op0;
  dual_issue_pkg::mem_op_t    mem_op1;
  dual_issue_pkg::mem_op_t    ex_mem_op;
  dual_issue_pkg::pipe_mask_t stall0;
  dual_issue_pkg::pipe_mask_t stall1;
  dual_issue_pkg::pipe_mask_t nop0;
  dual_issue_pkg::pipe_mask_t nop1;
  dual_issue_pkg::pipe_mask_t flush0;
  dual_issue_pkg::pipe_mask_t flush1;
  logic [`INST_WIDTH-1:0]     dec_inst0;
  logic [`INST_WIDTH-1:0]     dec_inst1;
  logic [`INST_WIDTH-1:0]     ex_load_inst;
  logic                       ex0_load;
  logic                       ex1_load;
  logic                       first_q;
  logic                       pc_stall;

  slot_decode_if slot0 ();
  slot_decode_if slot1 ();

  assign pc_stall = stall0.pc || stall1.pc;

  // first travels with the pair, so it holds whenever the pair does.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      first_q <= 1'b0;
    end else if (!pc_stall) begin
      pc      <= pc + (`ADDR_WIDTH)'(2);
      first_q <= first;
    end
  end

  assign if_id0_d = '{valid: 1'b1, inst: inst0};
  assign if_id1_d = '{valid: 1'b1, inst: inst1};

  stage_reg #(.payload_t(dual_issue_pkg::if_id_t)) u_if_id0 (
    .clk   (clk),
    .reset (reset),
    .stall (stall0.if_id),
    .flush (flush0.if_id || nop0.if_id),
    .d     (if_id0_d),
    .q     (if_id0_q)
  );

  stage_reg #(.payload_t(dual_issue_pkg::if_id_t)) u_if_id1 (
    .clk   (clk),
    .reset (reset),
    .stall (stall1.if_id),
    .flush (flush1.if_id || nop1.if_id),
    .d     (if_id1_d),
    .q     (if_id1_q)
  );

  // an empty slot decodes as a nop.
  assign dec_inst0 = if_id0_q.valid ? if_id0_q.inst : '0;
  assign dec_inst1 = if_id1_q.valid ? if_id1_q.inst : '0;

  inst_decode u_decode0 (.inst(dec_inst0), .slot(slot0.decoder), .mem_op(mem_op0));
  inst_decode u_decode1 (.inst(dec_inst1), .slot(slot1.decoder), .mem_op(mem_op1));

  // load in EX, lane 0 checked first.
  assign ex0_load     = id_ex0_q.valid && (id_ex0_q.mem_op == dual_issue_pkg::mem_read);
  assign ex1_load     = id_ex1_q.valid && (id_ex1_q.mem_op == dual_issue_pkg::mem_read);
  assign ex_load_inst = ex0_load ? id_ex0_q.inst : id_ex1_q.inst;
  assign ex_mem_op    = (ex0_load || ex1_load) ? dual_issue_pkg::mem_read
                                               : dual_issue_pkg::mem_none;

  hazard_detection_unit u_hazard (
    .load_instruction (ex_load_inst),
    .mem_op           (ex_mem_op),
    .first            (first_q),
    .slot0            (slot0.hazard),
    .slot1            (slot1.hazard),
    .stall0           (stall0),
    .nop0             (nop0),
    .stall1           (stall1),
    .nop1             (nop1),
    .flush0           (flush0),
    .flush1           (flush1)
  );

  assign id_ex0_d = '{valid: if_id0_q.valid, inst: if_id0_q.inst, mem_op: mem_op0};
  assign id_ex1_d = '{valid: if_id1_q.valid, inst: if_id1_q.inst, mem_op: mem_op1};

  stage_reg #(.payload_t(dual_issue_pkg::id_ex_t)) u_id_ex0 (
    .clk   (clk),
    .reset (reset),
    .stall (stall0.id_ex),
    .flush (flush0.id_ex || nop0.id_ex),
    .d     (id_ex0_d),
    .q     (id_ex0_q)
  );

  stage_reg #(.payload_t(dual_issue_pkg::id_ex_t)) u_id_ex1 (
    .clk   (clk),
    .reset (reset),
    .stall (stall1.id_ex),
    .flush (flush1.id_ex || nop1.id_ex),
    .d     (id_ex1_d),
    .q     (id_ex1_q)
  );

  assign ex0_valid = id_ex0_q.valid;
  assign ex0_inst  = id_ex0_q.inst;
  assign ex1_valid = id_ex1_q.valid;
  assign ex1_inst  = id_ex1_q.inst;

endmodule

/* tb_dual_issue_front.sv */
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module tb_dual_issue_front;

  localparam int TIMEOUT_CYCLES = 1000; // five tests, about 600 cycles in all.
  localparam logic [5:0] OP_ALU  = 6'b000001;
  localparam logic [5:0] OP_ALUI = 6'b010001;
  localparam logic [5:0] OP_JMP  = 6'b110001;

  logic        clk;
  logic        reset;
  logic [31:0] inst0;
  logic [31:0] inst1;
  logic        first;
  logic [15:0] pc;
  logic        ex0_valid;
  logic [31:0] ex0_inst;
  logic        ex1_valid;
  logic [31:0] ex1_inst;

  logic [31:0] prog [0:2047];
  logic        pair_first [0:1023];
  integer      seed = 32'had8;
  int          err_count = 0;
  int          n_checks = 0;
  int          cycle_count = 0;
  string       cur_test = "none";

  // reference state.
  logic [15:0] m_pc;
  logic        m_first;
  logic [1:0]  m_ifv;
  logic [1:0]  m_exv;
  logic [31:0] m_ifi [0:1];
  logic [31:0] m_exi [0:1];
  logic        m_ld;
  logic [4:0]  m_lrt;
  logic        m_ld_stall;
  logic [5:0]  m_old_dst;
  logic        m_split;

  dual_issue_front u_dual_issue_front (
    .clk       (clk),
    .reset     (reset),
    .inst0     (inst0),
    .inst1     (inst1),
    .first     (first),
    .pc        (pc),
    .ex0_valid (ex0_valid),
    .ex0_inst  (ex0_inst),
    .ex1_valid (ex1_valid),
    .ex1_inst  (ex1_inst)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] mk(input logic [5:0] op, input int rs, input int rt,
                                     input int rd);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'h0};
  endfunction

  // source fields per opcode, straight from the decode table.
  function automatic logic reads_reg(input logic valid, input logic [31:0] inst,
                                     input logic [4:0] r);
    logic [5:0] op;
    logic       use_rs;
    logic       use_rt;
    op     = inst[`OPCODE_MSB:`OPCODE_LSB];
    use_rs = 1'b0;
    use_rt = 1'b0;
    if (valid && op == `OP_CODE_JR) use_rs = 1'b1;
    else if (valid && op != `OP_CODE_NOP && op[5:4] == 2'b00) begin
      use_rs = 1'b1;
      use_rt = 1'b1;
    end else if (valid && (op[5:4] == 2'b01 || op == `OP_CODE_LW)) use_rs = 1'b1;
    else if (valid && op == `OP_CODE_SW) begin
      use_rs = 1'b1;
      use_rt = 1'b1;
    end else if (valid && op == `OP_CODE_SA) use_rt = 1'b1;
    return (use_rs && inst[`REG_RS_MSB:`REG_RS_LSB] == r) ||
           (use_rt && inst[`REG_RT_MSB:`REG_RT_LSB] == r);
  endfunction

  // {writes, register}.
  function automatic logic [5:0] dest_of(input logic valid, input logic [31:0] inst);
    logic [5:0] op;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    if (!valid) return 6'h0;
    if (op[5:4] == 2'b00 && op != `OP_CODE_NOP && op != `OP_CODE_JR)
      return {1'b1, inst[`REG_RD_MSB:`REG_RD_LSB]};
    if (op[5:4] == 2'b01 || op == `OP_CODE_LW || op == `OP_CODE_LA)
      return {1'b1, inst[`REG_RT_MSB:`REG_RT_LSB]};
    return 6'h0;
  endfunction

  function automatic logic is_load(input logic valid, input logic [31:0] inst);
    return valid && (inst[31:26] == `OP_CODE_LW || inst[31:26] == `OP_CODE_LA);
  endfunction

  assign m_ld       = is_load(m_exv[0], m_exi[0]) || is_load(m_exv[1], m_exi[1]);
  assign m_lrt      = is_load(m_exv[0], m_exi[0]) ? m_exi[0][20:16] : m_exi[1][20:16];
  assign m_ld_stall = m_ld && (reads_reg(m_ifv[0], m_ifi[0], m_lrt) ||
                               reads_reg(m_ifv[1], m_ifi[1], m_lrt));
  // m_first high means lane 1 is the older one.
  assign m_old_dst  = dest_of(m_ifv[m_first], m_ifi[m_first]);
  assign m_split    = !m_ld_stall && m_old_dst[5] &&
                      reads_reg(m_ifv[~m_first], m_ifi[~m_first], m_old_dst[4:0]);

  always @(posedge clk) begin
    if (reset) begin
      m_pc     <= '0;
      m_first  <= 1'b0;
      m_ifv    <= 2'b00;
      m_exv    <= 2'b00;
      m_ifi[0] <= '0;
      m_ifi[1] <= '0;
      m_exi[0] <= '0;
      m_exi[1] <= '0;
    end else if (m_ld_stall) begin
      m_exv    <= 2'b00; // pair waits, bubble in both lanes.
      m_exi[0] <= '0;
      m_exi[1] <= '0;
    end else if (m_split) begin
      m_exv[m_first]  <= m_ifv[m_first];
      m_exi[m_first]  <= m_ifi[m_first];
      m_exv[~m_first] <= 1'b0;
      m_exi[~m_first] <= '0;
      m_ifv[m_first]  <= 1'b0;
      m_ifi[m_first]  <= '0;
    end else begin
      m_pc     <= m_pc + 16'd2;
      m_first  <= first;
      m_ifv    <= 2'b11;
      m_ifi[0] <= inst0;
      m_ifi[1] <= inst1;
      m_exv    <= m_ifv;
      m_exi[0] <= m_ifi[0];
      m_exi[1] <= m_ifi[1];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      err_count++;
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic drive_inputs();
    inst0 = prog[pc[10:0]];
    inst1 = prog[pc[10:0] + 11'd1];
    first = pair_first[pc[10:1]];
  endtask

  // jumps touch no registers, low bits keep each word distinct.
  task automatic clear_program();
    for (int i = 0; i < 2048; i++) begin
      prog[i] = {OP_JMP, 26'(i)};
      if (i < 1024) pair_first[i] = 1'b0;
    end
  endtask

  task automatic fill_random();
    logic [5:0] ops [0:12];
    int         k;
    ops = '{`OP_CODE_NOP, `OP_CODE_JR, `OP_CODE_CMP, `OP_CODE_TEST, `OP_CODE_CMPI,
            `OP_CODE_TESTI, `OP_CODE_LW, `OP_CODE_SW, `OP_CODE_LA, `OP_CODE_SA,
            OP_ALU, OP_ALUI, OP_JMP};
    for (int i = 0; i < 2048; i++) begin
      k       = $unsigned($random(seed)) % 13;
      prog[i] = mk(ops[k], $random(seed) & 3, $random(seed) & 3, $random(seed) & 3);
      if (i < 1024) pair_first[i] = $random(seed);
    end
  endtask

  task automatic compare_model();
    check("pc", m_pc, pc);
    check("ex0_valid", m_exv[0], ex0_valid);
    check("ex0_inst", m_exi[0], ex0_inst);
    check("ex1_valid", m_exv[1], ex1_valid);
    check("ex1_inst", m_exi[1], ex1_inst);
  endtask

  task automatic run_test(input string name, input int cycles, input int exp_holds,
                          input int exp_bubbles, input bit latency);
    int          start_err;
    int          holds;
    int          bubbles;
    logic [15:0] prev_pc;
    cur_test  = name;
    start_err = err_count;
    holds     = 0;
    bubbles   = 0;
    @(negedge clk);
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    check("pc after reset", 32'h0, pc);
    check("ex0_valid after reset", 32'h0, ex0_valid);
    check("ex1_valid after reset", 32'h0, ex1_valid);
    reset = 1'b0;
    drive_inputs();
    prev_pc = pc;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      @(negedge clk);
      compare_model();
      if (pc == prev_pc) holds++;
      if (i >= 1) bubbles += !ex0_valid + !ex1_valid;
      if (latency && i == 1) begin // first pair two edges after fetch.
        check("first pair lane 0", prog[0], ex0_inst);
        check("first pair lane 1", prog[1], ex1_inst);
      end
      prev_pc = pc;
      drive_inputs();
    end
    if (exp_holds >= 0) begin
      check("pc hold cycles", exp_holds, holds);
      check("bubble lanes", exp_bubbles, bubbles);
    end
    $display("test %s finished, %0d mismatches", name, err_count - start_err);
  endtask

  initial begin
    reset = 1'b1;
    inst0 = '0;
    inst1 = '0;
    first = 1'b0;

    clear_program();
    for (int i = 0; i < 16; i += 2) begin
      prog[i]     = mk(OP_ALU, 1, 2, 3) | 32'(i);
      prog[i + 1] = mk(OP_ALU, 4, 5, 6) | 32'(i);
    end
    run_test("independent_pairs", 20, 0, 0, 1'b1);

    clear_program();
    prog[0] = mk(`OP_CODE_LW, 1, 7, 0);
    prog[1] = mk(OP_ALU, 2, 3, 4);
    prog[2] = mk(OP_ALU, 7, 8, 9);   // consumer of r7.
    prog[3] = mk(OP_ALU, 10, 11, 12);
    prog[4] = mk(`OP_CODE_LW, 1, 13, 0);
    prog[5] = mk(OP_ALU, 14, 15, 16);
    prog[6] = mk(OP_ALU, 1, 2, 13);  // r13 only as rd.
    prog[7] = mk(`OP_CODE_LA, 0, 13, 0);
    run_test("load_use", 20, 1, 2, 1'b1);

    clear_program();
    prog[0]       = mk(OP_ALU, 1, 2, 5);
    prog[1]       = mk(OP_ALU, 5, 6, 7);
    prog[2]       = mk(`OP_CODE_SW, 2, 9, 0);
    prog[3]       = mk(OP_ALUI, 1, 9, 0);
    pair_first[1] = 1'b1; // lane 1 older in the second pair.
    run_test("split", 20, 2, 4, 1'b0);

    clear_program();
    prog[0] = mk(`OP_CODE_LW, 1, 3, 0);
    prog[1] = mk(`OP_CODE_LA, 0, 3, 0);
    prog[2] = mk(`OP_CODE_NOP, 3, 3, 3);
    prog[3] = mk(`OP_CODE_LA, 0, 3, 0);
    prog[4] = mk(OP_JMP, 3, 3, 3);
    prog[5] = mk(`OP_CODE_NOP, 3, 3, 3);
    run_test("no_hazard", 16, 0, 0, 1'b1);

    fill_random();
    run_test("random_mix", 500, -1, -1, 1'b0);

    $display("%0d checks, %0d errors", n_checks, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* dual_issue_front.f */
+incdir+.
dual_issue_pkg.sv
slot_decode_if.sv
inst_decode.sv
hazard_detection_unit.sv
stage_reg.sv
dual_issue_front.sv
tb_dual_issue_front.sv
